//--- src/vdc_pkg.sv
package vdc_pkg;

	// register indices as seen through the address register
	localparam logic [5:0] REG_UA_HI    = 6'd18;
	localparam logic [5:0] REG_UA_LO    = 6'd19;
	localparam logic [5:0] REG_COPY_CFG = 6'd24;
	localparam logic [5:0] REG_RAM_CFG  = 6'd28;
	localparam logic [5:0] REG_WC       = 6'd30;
	localparam logic [5:0] REG_DA       = 6'd31;
	localparam logic [5:0] REG_BA_HI    = 6'd32;
	localparam logic [5:0] REG_BA_LO    = 6'd33;

	localparam int COPY_BIT = 7; // reg 24, copy instead of fill
	localparam int RAM_BIT  = 4; // reg 28, 64 kB layout
	localparam int RAM_AW   = 16;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_SET_UA_HI,
		OP_SET_UA_LO,
		OP_SET_BA_HI,
		OP_SET_BA_LO,
		OP_WRITE_DA,
		OP_READ_DA,
		OP_START_BLOCK
	} vdc_op_t;

	typedef struct packed {
		vdc_op_t    op;
		logic [7:0] data;
	} vdc_cmd_t;

	typedef struct packed {
		logic copy_mode;
		logic ram_layout;
	} vdc_cfg_t;

	typedef struct packed {
		logic [15:0] ua; // update address
		logic [7:0]  wc; // word count
		logic [7:0]  da; // data
		logic [15:0] ba; // block address
	} vdc_regs_t;

	// logical address to physical ram address
	function automatic logic [RAM_AW-1:0] fold_addr(input logic [15:0] addr,
		input logic ram64k, input logic ram_layout);
		logic [5:0] row;
		row = ram_layout ? addr[14:9] : addr[13:8];
		return {ram64k & addr[15], row, ram64k & addr[8], addr[7:0]};
	endfunction

endpackage

//--- src/vdc_regport.sv
`timescale 1ns/1ns

module vdc_regport import vdc_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       cs,
	input  logic       rs,
	input  logic       we,
	input  logic [7:0] db_in,
	input  vdc_regs_t  regs,
	input  logic       busy,
	output vdc_cmd_t   cmd,
	output vdc_cfg_t   cfg,
	output logic [7:0] db_out
);

	logic [5:0] reg_sel; // address register
	vdc_op_t    op_dec;
	logic [7:0] rd_data;

	// turn a data access into an engine command
	always_comb begin
		op_dec = OP_NONE;
		if (cs && rs) begin
			if (we) begin
				case (reg_sel)
					REG_UA_HI: op_dec = OP_SET_UA_HI;
					REG_UA_LO: op_dec = OP_SET_UA_LO;
					REG_WC:    op_dec = OP_START_BLOCK;
					REG_DA:    op_dec = OP_WRITE_DA;
					REG_BA_HI: op_dec = OP_SET_BA_HI;
					REG_BA_LO: op_dec = OP_SET_BA_LO;
					default:   op_dec = OP_NONE;
				endcase
			end else if (reg_sel == REG_DA) begin
				op_dec = OP_READ_DA; // triggers read-ahead
			end
		end
	end

	always_comb begin
		rd_data = 8'h00;
		case (reg_sel)
			REG_UA_HI:    rd_data = regs.ua[15:8];
			REG_UA_LO:    rd_data = regs.ua[7:0];
			REG_COPY_CFG: rd_data[COPY_BIT] = cfg.copy_mode;
			REG_RAM_CFG:  rd_data[RAM_BIT] = cfg.ram_layout;
			REG_WC:       rd_data = regs.wc;
			REG_DA:       rd_data = regs.da; // value before the read-ahead lands
			REG_BA_HI:    rd_data = regs.ba[15:8];
			REG_BA_LO:    rd_data = regs.ba[7:0];
			default:      rd_data = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_sel <= '0;
			cfg     <= '0;
			cmd     <= '0;
		end else begin
			cmd.op   <= op_dec; // one-cycle strobe
			cmd.data <= db_in;
			if (cs && !rs && we)
				reg_sel <= db_in[5:0];
			if (cs && rs && we) begin
				if (reg_sel == REG_COPY_CFG)
					cfg.copy_mode <= db_in[COPY_BIT];
				if (reg_sel == REG_RAM_CFG)
					cfg.ram_layout <= db_in[RAM_BIT];
			end
		end
	end

	// status or selected register, valid the cycle after the access
	always_ff @(posedge clk) begin
		if (cs && !we)
			db_out <= rs ? rd_data : {busy, 7'b0};
	end

endmodule

//--- src/vdc_ramiface.sv
`timescale 1ns/1ns

module vdc_ramiface import vdc_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  vdc_cmd_t          cmd,
	input  vdc_cfg_t          cfg,
	input  logic              ram64k,
	input  logic [7:0]        ram_rdata,
	output vdc_regs_t         regs,
	output logic              busy,
	output logic              ram_we,
	output logic [RAM_AW-1:0] ram_addr,
	output logic [7:0]        ram_wdata
);

	typedef enum logic [3:0] {
		S_RESET,
		S_IDLE,
		S_READNEXT,
		S_READ0,
		S_READ1,
		S_WRITE,
		S_FILL0,
		S_FILL1,
		S_COPY0,
		S_COPY1,
		S_COPY2
	} state_t;

	state_t      state;
	logic [7:0]  counter;
	logic [15:0] addr_q; // logical address, folded on the way out
	logic [7:0]  wdata_q;
	logic        we_q;

	assign busy     = (state != S_IDLE);
	assign ram_we   = we_q;
	assign ram_addr = fold_addr(addr_q, ram64k, cfg.ram_layout);
	// copy writes straight from the read port
	assign ram_wdata = (state == S_COPY2) ? ram_rdata : wdata_q;

	always_ff @(posedge clk) begin
		we_q <= 1'b0;

		case (state)
			S_RESET: begin
				regs    <= '0;
				counter <= '0;
				addr_q  <= '0;
				wdata_q <= '0;
				state   <= S_IDLE;
			end

			S_IDLE: begin
				case (cmd.op)
					OP_SET_UA_HI: begin
						regs.ua[15:8] <= cmd.data;
						addr_q        <= {cmd.data, regs.ua[7:0]};
						state         <= S_READ0;
					end
					OP_SET_UA_LO: begin
						regs.ua[7:0] <= cmd.data;
						addr_q       <= {regs.ua[15:8], cmd.data};
						state        <= S_READ0;
					end
					OP_SET_BA_HI: regs.ba[15:8] <= cmd.data; // no ram access
					OP_SET_BA_LO: regs.ba[7:0]  <= cmd.data;
					OP_WRITE_DA: begin
						wdata_q <= cmd.data;
						addr_q  <= regs.ua;
						we_q    <= 1'b1;
						state   <= S_WRITE;
					end
					OP_READ_DA: begin
						addr_q <= regs.ua + 16'd1;
						state  <= S_READNEXT;
					end
					OP_START_BLOCK: begin
						// WC keeps the written count, counter does the work
						regs.wc <= cmd.data;
						counter <= cmd.data;
						state   <= cfg.copy_mode ? S_COPY0 : S_FILL0;
					end
					default: state <= S_IDLE;
				endcase
			end

			S_WRITE: begin
				addr_q <= regs.ua + 16'd1;
				state  <= S_READNEXT;
			end
			S_READNEXT: begin
				regs.ua <= regs.ua + 16'd1;
				state   <= S_READ1;
			end
			S_READ0: state <= S_READ1; // ram read in flight
			S_READ1: begin
				regs.da <= ram_rdata;
				state   <= S_IDLE;
			end

			S_FILL0: begin
				addr_q  <= regs.ua;
				wdata_q <= regs.da;
				we_q    <= 1'b1;
				state   <= S_FILL1;
			end
			S_FILL1: begin
				regs.ua <= regs.ua + 16'd1;
				if (counter != 8'd1) begin // count 0 runs 256 times
					addr_q  <= regs.ua + 16'd1;
					counter <= counter - 8'd1;
					we_q    <= 1'b1;
					state   <= S_FILL1;
				end else begin
					state <= S_IDLE;
				end
			end

			S_COPY0: begin
				addr_q <= regs.ba;
				state  <= S_COPY1;
			end
			S_COPY1: begin
				regs.ba <= regs.ba + 16'd1;
				counter <= counter - 8'd1;
				addr_q  <= regs.ua;
				we_q    <= 1'b1;
				state   <= S_COPY2;
			end
			S_COPY2: begin
				regs.ua <= regs.ua + 16'd1;
				if (counter != 8'd0) begin
					addr_q <= regs.ba; // already advanced
					state  <= S_COPY1;
				end else begin
					state <= S_IDLE;
				end
			end

			default: state <= S_RESET;
		endcase

		if (reset) begin
			state <= S_RESET;
			we_q  <= 1'b0;
		end
	end

endmodule

//--- src/vdc_ram.sv
`timescale 1ns/1ns

module vdc_ram import vdc_pkg::*; (
	input  logic              clk,
	input  logic              we,
	input  logic [RAM_AW-1:0] addr,
	input  logic [7:0]        wdata,
	output logic [7:0]        rdata
);

	logic [7:0] mem [0:2**RAM_AW-1];

	// registered read, new data on a write
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
			rdata     <= wdata;
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

//--- src/vdc_top.sv
`timescale 1ns/1ns

module vdc_top import vdc_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       ram64k, // 64 kB fitted
	input  logic       cs,
	input  logic       rs,
	input  logic       we,
	input  logic [7:0] db_in,
	output logic [7:0] db_out
);

	vdc_cmd_t          cmd;
	vdc_cfg_t          cfg;
	vdc_regs_t         regs;
	logic              busy;
	logic              ram_we;
	logic [RAM_AW-1:0] ram_addr;
	logic [7:0]        ram_wdata;
	logic [7:0]        ram_rdata;

	vdc_regport u_regport (
		.clk    (clk),
		.reset  (reset),
		.cs     (cs),
		.rs     (rs),
		.we     (we),
		.db_in  (db_in),
		.regs   (regs),
		.busy   (busy),
		.cmd    (cmd),
		.cfg    (cfg),
		.db_out (db_out)
	);

	vdc_ramiface u_ramiface (
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd),
		.cfg       (cfg),
		.ram64k    (ram64k),
		.ram_rdata (ram_rdata),
		.regs      (regs),
		.busy      (busy),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata)
	);

	vdc_ram u_ram (
		.clk   (clk),
		.we    (ram_we),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

endmodule

//--- verif/vdc_props.sv
`timescale 1ns/1ns

module vdc_props import vdc_pkg::*; (
	input logic       clk,
	input logic       reset,
	input logic       idle,
	input logic       fill,
	input logic       busy,
	input logic       ram_we,
	input logic [7:0] counter,
	input logic [7:0] wc,
	input vdc_op_t    cmd_op
);

	int fail_count = 0; // read by the testbench at the end

	a_no_write_idle: assert property (@(posedge clk) disable iff (reset) idle |-> !ram_we)
		else begin
			fail_count++;
			$error("ram write enable high while idle");
		end

	// idle stays idle unless a command needs the ram
	a_idle_not_busy: assert property (@(posedge clk) disable iff (reset)
		(idle && (cmd_op == OP_NONE || cmd_op == OP_SET_BA_HI || cmd_op == OP_SET_BA_LO))
		|=> !busy)
		else begin
			fail_count++;
			$error("busy high after an idle cycle without a ram command");
		end

	// last fill beat must end the fill, never roll over
	a_fill_no_wrap: assert property (@(posedge clk) disable iff (reset)
		(fill && counter == 8'd1) |=> !fill)
		else begin
			fail_count++;
			$error("fill went on past the beat with count one");
		end

	a_drop_keeps_wc: assert property (@(posedge clk) disable iff (reset)
		(busy && cmd_op != OP_NONE) |=> $stable(wc))
		else begin
			fail_count++;
			$error("command accepted while busy changed wc");
		end

endmodule

bind vdc_ramiface vdc_props u_props (
	.clk     (clk),
	.reset   (reset),
	.idle    (state == S_IDLE),
	.fill    (state == S_FILL1),
	.busy    (busy),
	.ram_we  (ram_we),
	.counter (counter),
	.wc      (regs.wc),
	.cmd_op  (cmd.op)
);

//--- verif/vdc_checker.sv
`timescale 1ns/1ns

module vdc_checker import vdc_pkg::*; (
	input  logic       clk,
	input  logic       cs,
	input  logic       we,
	input  logic       check_en, // this access carries an expected value
	input  logic [7:0] exp_data,
	input  logic [7:0] db_out,
	output int         errors
);

	logic       pending = 1'b0;
	logic [7:0] pending_exp = 8'h00;
	int         err_count = 0;

	assign errors = err_count;

	// latch on the access cycle, compare one cycle later when db_out is settled
	always @(posedge clk) begin
		pending     <= cs && !we && check_en;
		pending_exp <= exp_data;
		if (pending && db_out !== pending_exp) begin
			err_count <= err_count + 1;
			$display("MISMATCH at %0t: db_out got %02h, expected %02h",
				$time, db_out, pending_exp);
		end
	end

endmodule

//--- verif/vdc_tb.sv
`timescale 1ns/1ns

module vdc_tb import vdc_pkg::*; ();

	logic       clk = 1'b0;
	logic       reset = 1'b1;
	logic       ram64k = 1'b1;
	logic       cs = 1'b0;
	logic       rs = 1'b0;
	logic       we = 1'b0;
	logic [7:0] db_in = 8'h00;
	logic [7:0] db_out;
	logic       check_en = 1'b0;
	logic [7:0] exp_data = 8'h00;
	int         mismatches;
	int         timeouts = 0;
	integer     seed = 32'h60d5d94c;

	// reference model of memory and engine registers
	logic [7:0]  m_mem [0:65535];
	logic [15:0] m_ua = '0;
	logic [7:0]  m_wc = '0;
	logic [7:0]  m_da = '0;
	logic [15:0] m_ba = '0;
	logic        m_copy = 1'b0;
	logic        m_layout = 1'b0;

	always #50 clk = ~clk;

	vdc_top u_vdc_top (.clk(clk), .reset(reset), .ram64k(ram64k), .cs(cs), .rs(rs),
		.we(we), .db_in(db_in), .db_out(db_out));

	vdc_checker u_checker (.clk(clk), .cs(cs), .we(we), .check_en(check_en),
		.exp_data(exp_data), .db_out(db_out), .errors(mismatches));

	function automatic logic [15:0] phys(input logic [15:0] a);
		logic [15:0] p;
		p = a;
		if (!m_layout)
			p[14:9] = a[13:8]; // row from bits 13..8, bit 14 ignored
		p[15] = a[15] & ram64k;
		p[8]  = a[8] & ram64k;
		return p;
	endfunction

	function automatic logic [7:0] expect_reg(input logic [5:0] r);
		case (r)
			REG_UA_HI: return m_ua[15:8];
			REG_UA_LO: return m_ua[7:0];
			REG_WC:    return m_wc;
			REG_DA:    return m_da;
			REG_BA_HI: return m_ba[15:8];
			REG_BA_LO: return m_ba[7:0];
			default:   return 8'h00;
		endcase
	endfunction

	function automatic void model_write(input logic [5:0] r, input logic [7:0] d);
		int n;
		case (r)
			REG_UA_HI:    m_ua[15:8] = d;
			REG_UA_LO:    m_ua[7:0] = d;
			REG_BA_HI:    m_ba[15:8] = d;
			REG_BA_LO:    m_ba[7:0] = d;
			REG_COPY_CFG: m_copy = d[7];
			REG_RAM_CFG:  m_layout = d[4];
			REG_DA: begin
				m_mem[phys(m_ua)] = d;
				m_ua = m_ua + 16'd1;
			end
			REG_WC: begin
				m_wc = d;
				n = (d == 8'd0) ? 256 : d; // zero count means 256
				for (int i = 0; i < n; i++) begin
					if (m_copy) begin
						m_mem[phys(m_ua)] = m_mem[phys(m_ba)];
						m_ba = m_ba + 16'd1;
					end else
						m_mem[phys(m_ua)] = m_da;
					m_ua = m_ua + 16'd1;
				end
			end
			default: ;
		endcase
		if (r == REG_UA_HI || r == REG_UA_LO || r == REG_DA)
			m_da = m_mem[phys(m_ua)]; // read-ahead
	endfunction

	task automatic bus_access(input logic rs_i, input logic we_i, input logic [7:0] d,
		input logic chk, input logic [7:0] expv);
		@(posedge clk);
		cs       <= 1'b1;
		rs       <= rs_i;
		we       <= we_i;
		db_in    <= d;
		check_en <= chk;
		exp_data <= expv;
		@(posedge clk);
		cs       <= 1'b0;
		check_en <= 1'b0;
	endtask

	task automatic wait_idle();
		int cycles = 0;
		do begin
			bus_access(1'b0, 1'b0, 8'h00, 1'b0, 8'h00);
			@(posedge clk); // status now in db_out
			cycles += 3;
		end while (db_out[7] && cycles < 2000 && timeouts == 0);
		if (db_out[7] && timeouts == 0) begin
			$display("timeout: engine still busy after %0d cycles at %0t", cycles, $time);
			timeouts++;
		end
	endtask

	task automatic write_reg(input logic [5:0] r, input logic [7:0] d);
		wait_idle();
		bus_access(1'b0, 1'b1, {2'b00, r}, 1'b0, 8'h00);
		bus_access(1'b1, 1'b1, d, 1'b0, 8'h00);
		model_write(r, d);
	endtask

	task automatic read_reg(input logic [5:0] r);
		wait_idle();
		bus_access(1'b0, 1'b1, {2'b00, r}, 1'b0, 8'h00);
		bus_access(1'b1, 1'b0, 8'h00, 1'b1, expect_reg(r));
		if (r == REG_DA) begin
			m_ua = m_ua + 16'd1;
			m_da = m_mem[phys(m_ua)];
		end
	endtask

	task automatic set_ua(input logic [15:0] a);
		write_reg(REG_UA_HI, a[15:8]);
		write_reg(REG_UA_LO, a[7:0]);
	endtask

	initial begin
		logic [15:0] base;
		int          n;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// writes with auto-increment, read back through DA
		write_reg(REG_RAM_CFG, 8'h10);
		base = 16'($random(seed));
		set_ua(base);
		repeat (16) write_reg(REG_DA, 8'($random(seed)));
		set_ua(base);
		repeat (16) read_reg(REG_DA);
		read_reg(REG_UA_HI);
		read_reg(REG_UA_LO);

		// fills, first one with count 256
		for (int t = 0; t < 4; t++) begin
			n = (t == 0) ? 256 : 16 + {$random(seed)} % 200;
			base = 16'($random(seed));
			set_ua(base + 16'(n));
			write_reg(REG_DA, 8'($random(seed))); // guard after range
			set_ua(base - 16'd1);
			write_reg(REG_DA, 8'($random(seed))); // guard before range
			write_reg(REG_DA, 8'($random(seed))); // fill value
			set_ua(base);
			write_reg(REG_WC, 8'(n));
			bus_access(1'b0, 1'b0, 8'h00, 1'b1, 8'h80);
			bus_access(1'b0, 1'b1, {2'b00, REG_DA}, 1'b0, 8'h00);
			bus_access(1'b1, 1'b1, 8'($random(seed)), 1'b0, 8'h00); // dropped, still busy
			bus_access(1'b0, 1'b1, {2'b00, REG_WC}, 1'b0, 8'h00);
			bus_access(1'b1, 1'b1, 8'(n + 1), 1'b0, 8'h00); // second block start, dropped
			read_reg(REG_WC);
			read_reg(REG_UA_HI);
			read_reg(REG_UA_LO);
			read_reg(REG_DA);
			set_ua(base - 16'd1);
			repeat (n + 2) read_reg(REG_DA);
		end

		// copies to a disjoint range
		write_reg(REG_COPY_CFG, 8'h80);
		for (int t = 0; t < 2; t++) begin
			n = 1 + {$random(seed)} % 64;
			base = 16'($random(seed));
			set_ua(base);
			repeat (n) write_reg(REG_DA, 8'($random(seed)));
			write_reg(REG_BA_HI, base[15:8]);
			write_reg(REG_BA_LO, base[7:0]);
			set_ua(base ^ 16'h8000);
			write_reg(REG_WC, 8'(n));
			read_reg(REG_BA_HI);
			read_reg(REG_BA_LO);
			read_reg(REG_UA_HI);
			read_reg(REG_UA_LO);
			read_reg(REG_WC);
			set_ua(base ^ 16'h8000);
			repeat (n) read_reg(REG_DA);
		end
		write_reg(REG_COPY_CFG, 8'h00);

		// 16 kB aliasing, then 64 kB with both layouts
		@(posedge clk);
		ram64k <= 1'b0;
		base = 16'($random(seed));
		set_ua(base);
		write_reg(REG_DA, 8'($random(seed)));
		set_ua(base ^ 16'h8100);
		read_reg(REG_DA);
		@(posedge clk);
		ram64k <= 1'b1;
		write_reg(REG_RAM_CFG, 8'h00);
		set_ua(base);
		write_reg(REG_DA, 8'($random(seed)));
		set_ua(base ^ 16'h4000);
		read_reg(REG_DA);
		write_reg(REG_RAM_CFG, 8'h10);
		set_ua(base);
		read_reg(REG_DA);

		repeat (4) @(posedge clk);
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, u_vdc_top.u_ramiface.u_props.fail_count);
		if (mismatches == 0 && timeouts == 0 && u_vdc_top.u_ramiface.u_props.fail_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- sim.f
src/vdc_pkg.sv
src/vdc_regport.sv
src/vdc_ramiface.sv
src/vdc_ram.sv
src/vdc_top.sv
verif/vdc_props.sv
verif/vdc_checker.sv
verif/vdc_tb.sv
